// ==== all.f ====
hw/pgx_pkg.sv
hw/pgx_job_queue.sv
hw/pgx_wr_mngr.sv
hw/pgx_axi_wr_port.sv
hw/pgx_top.sv
sim/pgx_sva.sv
sim/pgx_checker.sv
sim/pgx_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = pgx_tb
FILELIST  = all.f
OBJ       = obj_dir
PASS      = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx '$(PASS)'

clean:
	rm -rf $(OBJ)

// ==== sim/pgx_tb.sv ====
`timescale 1ns/1ns

module pgx_tb;
	import pgx_pkg::*;

	typedef struct packed {
		pgx_job_t    job;
		logic        bp;      // random aw_ready, w_ready and b_valid
		logic        gap;     // wait for done before the next row
		logic [7:0]  writes;  // expected writes of this job
	} row_t;

	logic clk_i, rst_ni, job_valid, job_ready, bp_en;
	logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready, done;
	pgx_job_t           job;
	logic [ADDR_W-1:0]  aw_addr;
	logic [DATA_W-1:0]  w_data;
	logic [STRB_W-1:0]  w_strb;
	logic [31:0]        lfsr;
	row_t               rows [$];
	int err_cnt, done_cnt, aw_cnt, pending;
	int cycles = 0;
	int limit = 0;
	int tb_errs = 0;

	pgx_top dut0 (.*);

	pgx_checker chk0 (
		.clk_i, .rst_ni, .job_valid, .job_ready, .job,
		.aw_valid, .aw_ready, .aw_addr, .w_valid, .w_ready, .w_data, .w_strb,
		.b_valid, .b_ready,
		.done, .err_cnt, .done_cnt, .aw_cnt, .pending
	);

	always #20 clk_i = ~clk_i;

	// taps 32,22,2,1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic row_t make_row(input pgx_op_e op, input logic [47:0] base,
		input logic [4:0] cnt, input logic [15:0] fill, input logic [47:0] way, nxt,
		input logic [META_W-1:0] meta, input logic bp, gap, input logic [7:0] writes);
		row_t r;
		r.job = '{op: op, page_base: base, line_cnt: cnt, fill: fill,
			way_ptr: way, next_ptr: nxt, meta: meta};
		r.bp     = bp;
		r.gap    = gap;
		r.writes = writes;
		return r;
	endfunction

	task automatic load_table();
		rows.push_back(make_row(OP_COMPRESS, 48'h0000_1000_0000, 5'd5, 16'ha5c3,
			48'h0000_0800_0040, 48'h0000_0800_0080, {25{16'h3c96}}, 1'b0, 1'b1, 8'd6));
		rows.push_back(make_row(OP_DECOMPRESS, 48'h0000_2000_0000, 5'd0, 16'h5a0f,
			48'h0000_0800_00c0, 48'h0000_0800_0100, {50{8'h71}}, 1'b0, 1'b1, 8'd65));
		rows.push_back(make_row(OP_META_UPDATE, 48'h0, 5'd0, 16'h0,
			48'h0000_0800_0140, 48'h0000_0800_0180, {10{40'h0123456789}}, 1'b0, 1'b1, 8'd1));
		rows.push_back(make_row(OP_COMPRESS, 48'h0000_1000_0000, 5'd5, 16'ha5c3,
			48'h0000_0800_0040, 48'h0000_0800_0080, {25{16'h3c96}}, 1'b1, 1'b1, 8'd6));
		// three jobs back to back, the last under back-pressure
		rows.push_back(make_row(OP_COMPRESS, 48'h0000_3000_0400, 5'd3, 16'h1111,
			48'h0000_0800_0200, 48'h0000_0800_0240, {25{16'hbeef}}, 1'b0, 1'b0, 8'd4));
		rows.push_back(make_row(OP_META_UPDATE, 48'h0, 5'd0, 16'h0,
			48'h0000_0800_0280, 48'h0000_0800_02c0, {50{8'he4}}, 1'b0, 1'b0, 8'd1));
		rows.push_back(make_row(OP_COMPRESS, 48'h0000_4000_fc00, 5'd16, 16'hc001,
			48'h0000_0800_0300, 48'h0000_0800_0340, {25{16'h0f0f}}, 1'b1, 1'b1, 8'd17));
	endtask

	task automatic wait_done(input int n);
		while (done_cnt < n) begin
			@(posedge clk_i);
			#1;
		end
	endtask

	task automatic apply_row(input row_t row, input int sent);
		bp_en     = row.bp;
		job       = row.job;
		job_valid = 1'b1;
		do @(posedge clk_i); while (!job_ready);
		#1;
		job_valid = 1'b0;   // raised again at once by a back-to-back row
		if (row.gap) wait_done(sent);
	endtask

	// bus side responses, one lfsr bit per signal and cycle
	initial begin
		logic use_bp;
		aw_ready = 1'b1;
		w_ready  = 1'b1;
		b_valid  = 1'b0;
		lfsr     = 32'h7b011062;
		forever begin
			@(posedge clk_i);
			use_bp = bp_en;
			#1;
			if (use_bp) begin
				lfsr     = lfsr_next(lfsr);
				aw_ready = lfsr[0];
				lfsr     = lfsr_next(lfsr);
				w_ready  = lfsr[0];
				lfsr     = lfsr_next(lfsr);
				b_valid  = lfsr[0];
			end else begin
				aw_ready = 1'b1;
				w_ready  = 1'b1;
				b_valid  = 1'b1;
			end
		end
	end

	always @(posedge clk_i) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		int expected;
		clk_i     = 1'b0;
		rst_ni    = 1'b1;
		job_valid = 1'b0;
		job       = '0;
		bp_en     = 1'b0;
		expected  = 0;
		load_table();
		limit = 200;
		foreach (rows[r]) limit += 40 * int'(rows[r].writes);
		#1 rst_ni = 1'b0;
		repeat (8) @(posedge clk_i);
		#1 rst_ni = 1'b1;
		repeat (2) @(posedge clk_i);
		#1;
		foreach (rows[r]) begin
			expected += int'(rows[r].writes);
			apply_row(rows[r], r + 1);
			if (rows[r].gap && aw_cnt != expected) begin
				$display("CHECK FAILED at %0t: %0d writes after row %0d, expected %0d",
					$time, aw_cnt, r, expected);
				tb_errs++;
			end
		end
		repeat (4) @(posedge clk_i);
		if (done_cnt != rows.size()) begin
			$display("CHECK FAILED at %0t: %0d done pulses, expected %0d", $time, done_cnt,
				rows.size());
			tb_errs++;
		end
		if (pending != 0) begin
			$display("ERROR at %0t: %0d expected writes never appeared", $time, pending);
			tb_errs++;
		end
		$display("%0d jobs, %0d done pulses, %0d writes, %0d errors", rows.size(), done_cnt,
			aw_cnt, err_cnt + tb_errs);
		if (err_cnt + tb_errs == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	bind pgx_wr_mngr pgx_sva sva_mngr (
		.clk_i, .rst_ni,
		.vld({beat_valid, beat_valid}), .rdy({beat_ready, beat_ready}), .payload(beat),
		.quiet(state == pgx_pkg::IDLE), .busy(1'b0), .pulse(1'b0)
	);

	bind pgx_axi_wr_port pgx_sva sva_port (
		.clk_i, .rst_ni,
		.vld({aw_valid, w_valid}), .rdy({aw_ready, w_ready}),
		.payload({aw_addr, w_data, w_strb, 1'b0}),
		.quiet(!done), .busy(tag_cnt != '0), .pulse(done)
	);

endmodule

// ==== sim/pgx_checker.sv ====
`timescale 1ns/1ns

module pgx_checker (
	input  logic                        clk_i,
	input  logic                        rst_ni,
	input  logic                        job_valid,
	input  logic                        job_ready,
	input  pgx_pkg::pgx_job_t           job,
	input  logic                        aw_valid,
	input  logic                        aw_ready,
	input  logic [pgx_pkg::ADDR_W-1:0]  aw_addr,
	input  logic                        w_valid,
	input  logic                        w_ready,
	input  logic [pgx_pkg::DATA_W-1:0]  w_data,
	input  logic [pgx_pkg::STRB_W-1:0]  w_strb,
	input  logic                        b_valid,
	input  logic                        b_ready,
	input  logic                        done,
	output int                          err_cnt,
	output int                          done_cnt,
	output int                          aw_cnt,
	output int                          pending
);
	import pgx_pkg::*;

	logic [ADDR_W-1:0]  exp_addr [$];
	logic [DATA_W-1:0]  exp_data [$];
	logic [STRB_W-1:0]  exp_strb [$];
	int                 job_end [$];   // running write count at each job end
	pgx_op_e            job_op [$];
	int errs = 0;
	int dones = 0;
	int aws = 0;
	int ws = 0;
	int bs = 0;
	int total = 0;
	int post_rst = 0;
	int left = 0;

	assign err_cnt  = errs;
	assign done_cnt = dones;
	assign aw_cnt   = aws;
	assign pending  = left;

	function automatic logic [DATA_W-1:0] line_data(input logic [15:0] fill, input int idx);
		logic [DATA_W-1:0] d;
		for (int k = 0; k < DATA_W / 16; k++) d[k*16 +: 16] = fill;
		d[15:0] = idx[15:0];   // line index overwrites the lowest copy
		return d;
	endfunction

	function automatic logic [DATA_W-1:0] meta_data(input pgx_job_t j);
		logic [DATA_W-1:0] d;
		d = '0;
		d[47:0]   = j.way_ptr;
		d[95:48]  = j.next_ptr;
		d[495:96] = j.meta;
		return d;
	endfunction

	task automatic mismatch(input string what, input logic [DATA_W-1:0] got, exp);
		$display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		errs++;
	endtask

	task automatic push_job(input pgx_job_t j);
		int n;
		logic [STRB_W-1:0] s;
		n = (j.op == OP_DECOMPRESS) ? PAGE_LINES : (j.op == OP_COMPRESS) ? int'(j.line_cnt) : 0;
		for (int i = 0; i < n; i++) begin
			exp_addr.push_back(j.page_base + ADDR_W'(i * LINE_BYTES));
			exp_data.push_back(line_data(j.fill, i));
			exp_strb.push_back({STRB_W{1'b1}});
		end
		s = '0;
		for (int b = 0; b < META_STRB; b++) s[b] = 1'b1;
		exp_addr.push_back(j.way_ptr);
		exp_data.push_back(meta_data(j));
		exp_strb.push_back(s);
		total += n + 1;
		job_end.push_back(total);
		job_op.push_back(j.op);
	endtask

	always @(posedge clk_i) begin
		int e;
		pgx_op_e o;
		if (!rst_ni || post_rst < 2) begin
			if (aw_valid || w_valid || b_ready || done)
				mismatch("aw_valid/w_valid/b_ready/done near reset",
					DATA_W'({aw_valid, w_valid, b_ready, done}), '0);
			if (!job_ready) mismatch("job_ready near reset", DATA_W'(job_ready), DATA_W'(1));
		end
		if (!rst_ni) begin
			post_rst = 0;
		end else begin
			if (post_rst < 2) post_rst++;
			if (job_valid && job_ready) push_job(job);
			// a response is only due for a write sent on both channels
			if (b_ready && (aws <= bs || ws <= bs)) begin
				$display("ERROR at %0t: b_ready high with no write awaiting a response", $time);
				errs++;
			end
			if (done) begin
				if (job_end.size() == 0) begin
					$display("ERROR at %0t: done pulse with no job in flight", $time);
					errs++;
				end else begin
					e = job_end.pop_front();
					o = job_op.pop_front();
					if (bs != e) begin
						$display("CHECK FAILED at %0t: done of job %0d after %0d responses, expected %0d",
							$time, dones, bs, e);
						errs++;
					end
					$display("job %0d %s done at %0t, %0d writes so far, %0d errors",
						dones, o.name(), $time, aws, errs);
				end
				dones++;
			end
			if (b_valid && b_ready) bs++;
			if (aw_valid && aw_ready) begin
				if (exp_addr.size() == 0) begin
					$display("ERROR at %0t: AW handshake with no write expected", $time);
					errs++;
				end else begin
					if (aw_addr !== exp_addr[0])
						mismatch("aw_addr", DATA_W'(aw_addr), DATA_W'(exp_addr[0]));
					void'(exp_addr.pop_front());
				end
				aws++;
			end
			if (w_valid && w_ready) begin
				if (exp_data.size() == 0) begin
					$display("ERROR at %0t: W handshake with no write expected", $time);
					errs++;
				end else begin
					if (w_data !== exp_data[0]) mismatch("w_data", w_data, exp_data[0]);
					if (w_strb !== exp_strb[0])
						mismatch("w_strb", DATA_W'(w_strb), DATA_W'(exp_strb[0]));
					void'(exp_data.pop_front());
					void'(exp_strb.pop_front());
				end
				ws++;
			end
			left = exp_addr.size() + exp_data.size();
		end
	end

endmodule

// ==== sim/pgx_sva.sv ====
`timescale 1ns/1ns

module pgx_sva (
	input  logic                                   clk_i,
	input  logic                                   rst_ni,
	input  logic [1:0]                             vld,      // one bit per channel
	input  logic [1:0]                             rdy,
	input  logic [$bits(pgx_pkg::pgx_beat_t)-1:0]  payload,
	input  logic                                   quiet,    // idle state or no done
	input  logic                                   busy,     // tags outstanding
	input  logic                                   pulse
);
	import pgx_pkg::*;

	// a stalled channel keeps its valid
	a_hold0: assert property (@(posedge clk_i) disable iff (!rst_ni)
		vld[0] && !rdy[0] |=> vld[0]) else $error("valid 0 dropped while stalled");
	a_hold1: assert property (@(posedge clk_i) disable iff (!rst_ni)
		vld[1] && !rdy[1] |=> vld[1]) else $error("valid 1 dropped while stalled");

	// payload is shared by both channels, so any stall freezes it
	a_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(vld[0] && !rdy[0]) || (vld[1] && !rdy[1]) |=> $stable(payload))
		else $error("payload changed while stalled");

	a_reset: assert property (@(posedge clk_i)
		!rst_ni |-> (vld == 2'b00) && quiet) else $error("not quiet in reset");

	// done follows the B handshake that popped the last tag
	a_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
		pulse |-> $past(busy)) else $error("done without outstanding tags");

endmodule

// ==== hw/pgx_top.sv ====
`timescale 1ns/1ns

module pgx_top (
	input  logic                        clk_i,
	input  logic                        rst_ni,
	input  logic                        job_valid,
	output logic                        job_ready,
	input  pgx_pkg::pgx_job_t           job,
	output logic                        aw_valid,
	input  logic                        aw_ready,
	output logic [pgx_pkg::ADDR_W-1:0]  aw_addr,
	output logic                        w_valid,
	input  logic                        w_ready,
	output logic [pgx_pkg::DATA_W-1:0]  w_data,
	output logic [pgx_pkg::STRB_W-1:0]  w_strb,
	input  logic                        b_valid,
	output logic                        b_ready,
	output logic                        done
);
	import pgx_pkg::*;

	logic       q_valid, q_ready;
	pgx_job_t   q_job;
	logic       beat_valid, beat_ready;
	pgx_beat_t  beat;

	// job side
	pgx_job_queue u_queue (
		.clk_i, .rst_ni,
		.job_valid, .job_ready, .job,
		.q_valid, .q_ready, .q_job
	);

	pgx_wr_mngr u_mngr (
		.clk_i, .rst_ni,
		.q_valid, .q_ready, .q_job,
		.beat_valid, .beat_ready, .beat
	);

	// bus side
	pgx_axi_wr_port u_port (
		.clk_i, .rst_ni,
		.beat_valid, .beat_ready, .beat,
		.aw_valid, .aw_ready, .aw_addr,
		.w_valid, .w_ready, .w_data, .w_strb,
		.b_valid, .b_ready, .done
	);

endmodule

// ==== hw/pgx_axi_wr_port.sv ====
`timescale 1ns/1ns

module pgx_axi_wr_port (
	input  logic                        clk_i,
	input  logic                        rst_ni,
	input  logic                        beat_valid,
	output logic                        beat_ready,
	input  pgx_pkg::pgx_beat_t          beat,
	output logic                        aw_valid,
	input  logic                        aw_ready,
	output logic [pgx_pkg::ADDR_W-1:0]  aw_addr,
	output logic                        w_valid,
	input  logic                        w_ready,
	output logic [pgx_pkg::DATA_W-1:0]  w_data,
	output logic [pgx_pkg::STRB_W-1:0]  w_strb,
	input  logic                        b_valid,
	output logic                        b_ready,
	output logic                        done
);
	import pgx_pkg::*;

	logic                  tag_mem [MAX_OUTSTANDING];  // job_last per write
	logic [TAG_PTR_W-1:0]  tag_wr, tag_rd;
	logic [TAG_CNT_W-1:0]  tag_cnt;
	logic [TAG_CNT_W-1:0]  aw_cred, w_cred;   // sent on each channel, B pending
	logic                  beat_take, aw_take, w_take, b_take;

	assign beat_ready = (!aw_valid || aw_ready) && (!w_valid || w_ready)
		&& (tag_cnt != TAG_CNT_W'(MAX_OUTSTANDING));
	assign beat_take  = beat_valid && beat_ready;
	assign aw_take    = aw_valid && aw_ready;
	assign w_take     = w_valid && w_ready;
	// a response is only due once both halves of the write went out
	assign b_ready    = (aw_cred != '0) && (w_cred != '0);
	assign b_take     = b_valid && b_ready;

	always_ff @(posedge clk_i) begin
		if (beat_take) begin
			aw_addr         <= beat.addr;
			w_data          <= beat.data;
			w_strb          <= beat.strb;
			tag_mem[tag_wr] <= beat.job_last;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			aw_valid <= 1'b0;
			w_valid  <= 1'b0;
			tag_wr   <= '0;
			tag_rd   <= '0;
			tag_cnt  <= '0;
			aw_cred  <= '0;
			w_cred   <= '0;
			done     <= 1'b0;
		end else begin
			// each slot frees on its own ready
			if (beat_take) begin
				aw_valid <= 1'b1;
				w_valid  <= 1'b1;
			end else begin
				if (aw_ready) aw_valid <= 1'b0;
				if (w_ready)  w_valid  <= 1'b0;
			end
			if (beat_take) tag_wr <= tag_wr + TAG_PTR_W'(1);
			if (b_take)    tag_rd <= tag_rd + TAG_PTR_W'(1);
			tag_cnt <= tag_cnt + TAG_CNT_W'(beat_take) - TAG_CNT_W'(b_take);
			aw_cred <= aw_cred + TAG_CNT_W'(aw_take) - TAG_CNT_W'(b_take);
			w_cred  <= w_cred + TAG_CNT_W'(w_take) - TAG_CNT_W'(b_take);
			done    <= b_take && tag_mem[tag_rd];  // end of job
		end
	end

endmodule

// ==== hw/pgx_wr_mngr.sv ====
`timescale 1ns/1ns

module pgx_wr_mngr (
	input  logic                clk_i,
	input  logic                rst_ni,
	input  logic                q_valid,
	output logic                q_ready,
	input  pgx_pkg::pgx_job_t   q_job,
	output logic                beat_valid,
	input  logic                beat_ready,
	output pgx_pkg::pgx_beat_t  beat
);
	import pgx_pkg::*;

	// state tells what gets loaded into the beat register next
	// NEXT means the job's final beat sits in the register
	pgx_state_e           state, state_d;
	pgx_job_t             job_q;
	pgx_beat_t            beat_d;
	logic [ADDR_W-1:0]    addr_q, addr_d;       // address of the next data line
	logic [LIDX_W-1:0]    line_idx, line_idx_d;
	logic [LIDX_W-1:0]    line_tot, line_tot_d;
	logic                 slot_free;
	logic                 take;
	logic                 load;

	function automatic logic [LIDX_W-1:0] total_lines(input pgx_job_t j);
		logic [LIDX_W-1:0] n;
		if (j.op == OP_DECOMPRESS) begin
			n = LIDX_W'(PAGE_LINES);
		end else begin
			n = LIDX_W'(j.line_cnt);
		end
		return n;
	endfunction

	// fill pattern over the whole line, line index in the low half-word
	function automatic pgx_beat_t line_beat(
		input logic [ADDR_W-1:0] addr,
		input logic [FILL_W-1:0] fill,
		input logic [LIDX_W-1:0] idx
	);
		pgx_beat_t b;
		b.addr     = addr;
		b.data     = {{(DATA_W/FILL_W - 1){fill}}, FILL_W'(idx)};
		b.strb     = '1;
		b.job_last = 1'b0;
		return b;
	endfunction

	// md line: pad, meta, next_ptr, way_ptr from the top down
	function automatic pgx_beat_t meta_beat(input pgx_job_t j);
		pgx_beat_t b;
		b.addr     = ADDR_W'(j.way_ptr);
		b.data     = {{(DATA_W - META_W - 2*PTR_W){1'b0}}, j.meta, j.next_ptr, j.way_ptr};
		b.strb     = {{(STRB_W - META_STRB){1'b0}}, {META_STRB{1'b1}}};
		b.job_last = 1'b1;
		return b;
	endfunction

	assign slot_free = !beat_valid || beat_ready;
	assign q_ready   = slot_free && (state == IDLE || state == NEXT);
	assign take      = q_valid && q_ready;

	always_comb begin
		state_d    = state;
		load       = 1'b0;
		beat_d     = beat;
		addr_d     = addr_q;
		line_idx_d = line_idx;
		line_tot_d = line_tot;
		case (state)
			IDLE, NEXT: begin
				if (take) begin
					// first beat comes straight from the queue head, no bubble
					load = 1'b1;
					if (q_job.op == OP_META_UPDATE) begin
						beat_d  = meta_beat(q_job);   // single write job
						state_d = NEXT;
					end else begin
						beat_d     = line_beat(q_job.page_base, q_job.fill, LIDX_W'(0));
						addr_d     = q_job.page_base + ADDR_W'(LINE_BYTES);
						line_idx_d = LIDX_W'(1);
						line_tot_d = total_lines(q_job);
						if (total_lines(q_job) == LIDX_W'(1)) begin
							state_d = META_WRITE;
						end else begin
							state_d = DATA_LINES;
						end
					end
				end else if (state == NEXT && beat_ready) begin
					state_d = IDLE;                   // last beat drained, nothing waiting
				end
			end
			DATA_LINES: begin
				if (slot_free) begin
					load       = 1'b1;
					beat_d     = line_beat(addr_q, job_q.fill, line_idx);
					addr_d     = addr_q + ADDR_W'(LINE_BYTES);
					line_idx_d = line_idx + LIDX_W'(1);
					if (line_idx + LIDX_W'(1) == line_tot) begin
						state_d = META_WRITE;
					end
				end
			end
			META_WRITE: begin
				if (slot_free) begin
					load    = 1'b1;
					beat_d  = meta_beat(job_q);
					state_d = NEXT;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state      <= IDLE;
			beat_valid <= 1'b0;
			line_idx   <= '0;
			line_tot   <= '0;
		end else begin
			state    <= state_d;
			line_idx <= line_idx_d;
			line_tot <= line_tot_d;
			if (load) begin
				beat_valid <= 1'b1;
			end else if (beat_ready) begin
				beat_valid <= 1'b0;
			end
		end
	end

	// payload registers
	always_ff @(posedge clk_i) begin
		beat   <= beat_d;
		addr_q <= addr_d;
		if (take) begin
			job_q <= q_job;
		end
	end

endmodule

// ==== hw/pgx_job_queue.sv ====
`timescale 1ns/1ns

module pgx_job_queue (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               job_valid,
	output logic               job_ready,
	input  pgx_pkg::pgx_job_t  job,
	output logic               q_valid,
	input  logic               q_ready,
	output pgx_pkg::pgx_job_t  q_job
);
	import pgx_pkg::*;

	pgx_job_t              mem [QUEUE_DEPTH];
	logic [QPTR_W-1:0]     wr_ptr;
	logic [QPTR_W-1:0]     rd_ptr;
	logic [QCNT_W-1:0]     count;
	logic                  push;
	logic                  pop;

	assign job_ready = (count != QCNT_W'(QUEUE_DEPTH));
	assign q_valid   = (count != '0);
	assign q_job     = mem[rd_ptr];   // head entry, valid only with q_valid

	assign push = job_valid && job_ready;
	assign pop  = q_valid && q_ready;

	// job storage
	always_ff @(posedge clk_i) begin
		if (push) begin
			mem[wr_ptr] <= job;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + QPTR_W'(1);  // wraps at depth 2
			end
			if (pop) begin
				rd_ptr <= rd_ptr + QPTR_W'(1);
			end
			case ({push, pop})
				2'b10:   count <= count + QCNT_W'(1);
				2'b01:   count <= count - QCNT_W'(1);
				default: count <= count;          // both or neither
			endcase
		end
	end

endmodule

// ==== hw/pgx_pkg.sv ====
package pgx_pkg;

	// bus and page geometry
	localparam int ADDR_W      = 48;           // byte address
	localparam int DATA_W      = 512;          // one cache line per beat
	localparam int STRB_W      = DATA_W / 8;
	localparam int LINE_BYTES  = 64;
	localparam int PAGE_LINES  = 64;           // full page on decompress
	localparam int META_W      = 400;          // 50 byte metadata block
	localparam int META_STRB   = 62;           // top two bytes of the md line unused
	localparam int PTR_W       = 48;           // way and next-way pointers
	localparam int FILL_W      = 16;
	localparam int LCNT_W      = 5;            // compress line count, 1..16
	localparam int LIDX_W      = 7;            // must hold PAGE_LINES

	// buffering
	localparam int QUEUE_DEPTH = 2;
	localparam int QPTR_W      = 1;
	localparam int QCNT_W      = 2;
	localparam int MAX_OUTSTANDING = 8;        // B responses in flight
	localparam int TAG_PTR_W   = 3;
	localparam int TAG_CNT_W   = 4;

	typedef enum logic [1:0] {
		OP_COMPRESS    = 2'd0,
		OP_DECOMPRESS  = 2'd1,
		OP_META_UPDATE = 2'd2
	} pgx_op_e;

	// manager states, see pgx_wr_mngr
	typedef enum logic [1:0] {
		IDLE       = 2'd0,
		DATA_LINES = 2'd1,
		META_WRITE = 2'd2,
		NEXT       = 2'd3
	} pgx_state_e;

	typedef struct packed {
		pgx_op_e            op;
		logic [ADDR_W-1:0]  page_base;  // first data line
		logic [LCNT_W-1:0]  line_cnt;   // compress only
		logic [FILL_W-1:0]  fill;
		logic [PTR_W-1:0]   way_ptr;    // also the md write address
		logic [PTR_W-1:0]   next_ptr;
		logic [META_W-1:0]  meta;
	} pgx_job_t;

	typedef struct packed {
		logic [ADDR_W-1:0]  addr;
		logic [DATA_W-1:0]  data;
		logic [STRB_W-1:0]  strb;
		logic               job_last;   // final write of its job
	} pgx_beat_t;

endpackage
